/* eeprom_ctrl.f */
eeprom_pkg.sv
i2c_bit_engine.sv
eeprom_wr.sv
eeprom_ctrl_top.sv
eeprom_model.sv
tb_eeprom.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - eeprom_pkg.sv
  - i2c_bit_engine.sv
  - eeprom_wr.sv
  - eeprom_ctrl_top.sv
  - target: simulation
    files:
      - eeprom_model.sv
      - tb_eeprom.sv

/* tb_eeprom.sv */
`default_nettype none

module tb_eeprom
  import eeprom_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ack_timeout = 1000;  // clk cycles

  logic       clk;
  logic       rst_n;
  logic       wr;
  logic       rd;
  ee_addr_t   addr;
  byte_t      data_drv;
  logic       data_oe;
  wire byte_t data;
  wire        ack;
  wire        scl;
  wire        sda;

  integer     seed = 94110;
  byte_t      sb_mem [0:2047];  // expected device contents

  pullup (sda);
  assign data = data_oe ? data_drv : 'z;

  eeprom_ctrl_top DUT (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .addr  (addr),
    .data  (data),
    .ack   (ack),
    .scl   (scl),
    .sda   (sda)
  );

  eeprom_model u_model (
    .scl (scl),
    .sda (sda)
  );

  always #10 clk = ~clk;

  task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                       input string what);
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // one full request, returns what data held during the ack cycle
  task automatic host_cycle(input logic w, input logic r, input ee_addr_t a,
                            input byte_t d, output byte_t q);
    int cycles;
    int stops;
    cycles = 0;
    stops  = u_model.stop_count;
    @(posedge clk);
    wr       <= w;
    rd       <= r;
    addr     <= a;
    data_drv <= d;
    data_oe  <= w;  // released for a read
    @(negedge clk);
    while (ack !== 1'b1) begin
      if (cycles == ack_timeout) begin
        $display("timed out after %0d cycles waiting for ack, address %h", cycles, a);
        $display("Some tests failed");
        $fatal(1, "no ack from the DUT");
      end
      cycles++;
      @(negedge clk);
    end
    q = data;
    @(posedge clk);
    wr      <= 1'b0;
    rd      <= 1'b0;
    data_oe <= 1'b0;
    check(stops + 1, u_model.stop_count, "one stop condition per transaction");
  endtask

  task automatic do_write(input ee_addr_t a, input byte_t d);
    byte_t q;
    host_cycle(1'b1, 1'b0, a, d, q);
    sb_mem[a] = d;
  endtask

  task automatic do_read(input ee_addr_t a);
    byte_t q;
    host_cycle(1'b0, 1'b1, a, 8'h00, q);
    check(sb_mem[a], q, $sformatf("read data at address %h", a));
    @(negedge clk);
    check(8'hzz, data, "data released after ack");
  endtask

  task automatic idle_bus();
    repeat (6) begin
      @(negedge clk);
      check(1'b0, ack, "ack low while idle");
      check(1'b1, scl, "scl high while idle");
      check(1'b1, sda, "sda released while idle");
      check(8'hzz, data, "data released while idle");
    end
  endtask

  task automatic write_read_same_addr();
    ee_addr_t a;
    byte_t    d;
    a = 11'h123;
    d = byte_t'($random(seed));
    do_write(a, d);
    do_read(a);
    check(d, u_model.mem[a], "model memory after write");
  endtask

  task automatic high_addr_bits();
    byte_t d;
    for (int hi = 0; hi < 8; hi++) begin
      d = {5'($random(seed)), 3'(hi)};  // low bits keep the eight bytes distinct
      do_write({3'(hi), 8'h5a}, d);
    end
    for (int hi = 0; hi < 8; hi++) begin
      do_read({3'(hi), 8'h5a});
    end
  endtask

  task automatic wr_rd_together();
    ee_addr_t a;
    byte_t    q;
    a = 11'h3c7;
    do_write(a, 8'h11);
    host_cycle(1'b1, 1'b1, a, 8'hc4, q);
    sb_mem[a] = 8'hc4;
    check(1'b0, u_model.last_op_read, "wr and rd together give a write");
    do_read(a);
  endtask

  task automatic random_traffic();
    ee_addr_t used [$];
    ee_addr_t a;
    for (int n = 0; n < 40; n++) begin
      if (n % 5 == 4) begin
        a = used[{$random(seed)} % used.size()];  // rewrite an earlier address
      end else begin
        a = ee_addr_t'($random(seed));
      end
      do_write(a, byte_t'($random(seed)));
      used.push_back(a);
    end
    foreach (used[k]) begin
      do_read(used[k]);
    end
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    wr       = 1'b0;
    rd       = 1'b0;
    addr     = '0;
    data_drv = '0;
    data_oe  = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    idle_bus();
    write_read_same_addr();
    high_addr_bits();
    wr_rd_together();
    random_traffic();
    check(0, u_model.bad_ctrl_count, "control bytes with a foreign device code");
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* eeprom_model.sv */
`default_nettype none

module eeprom_model
  import eeprom_pkg::*;
(
  input  wire scl,
  inout  wire sda
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time drive_delay = 30ns;  // after the master lets go, before scl rises

  typedef enum logic [2:0] {
    mdl_idle,
    mdl_rx,
    mdl_rx_ack,
    mdl_tx,
    mdl_tx_ack
  } mdl_state_t;

  byte_t      mem [0:2047];
  mdl_state_t state          = mdl_idle;
  byte_t      shift          = '0;
  int         bit_cnt        = 0;
  int         byte_cnt       = 0;     // bytes since the last start
  logic       rd_mode        = 1'b0;
  ee_addr_t   ptr            = '0;
  logic       pull_low       = 1'b0;
  logic       scl_q;
  logic       sda_q;
  int         stop_count     = 0;
  int         bad_ctrl_count = 0;
  logic       last_op_read   = 1'b0;
  int         i;

  assign sda = pull_low ? 1'b0 : 1'bz;  // open drain

  initial begin
    for (i = 0; i < 2048; i++) begin
      mem[i] = byte_t'((i * 29) ^ (i >> 5));
    end
  end

  // one received byte is complete
  task automatic take_byte();
    state = mdl_rx_ack;
    if (byte_cnt == 0) begin
      rd_mode = shift[0];
      if (shift[7:4] != ee_device_code) begin
        bad_ctrl_count++;
        state = mdl_idle;  // not our device, no ack
      end else if (!shift[0]) begin
        ptr[10:8] = shift[3:1];
      end
    end else if (byte_cnt == 1) begin
      ptr[7:0] = shift;
    end else begin
      mem[ptr]     = shift;
      last_op_read = 1'b0;
    end
    byte_cnt++;
  endtask

  always @(scl or sda) begin
    if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q) begin
      if (sda === 1'b0) begin  // start or repeated start
        state    = mdl_rx;
        bit_cnt  = 0;
        byte_cnt = 0;
        pull_low = 1'b0;
      end else if (sda === 1'b1) begin
        stop_count++;
        state = mdl_idle;
      end
    end else if (scl === 1'b1 && scl_q !== 1'b1) begin
      if (state == mdl_rx) begin
        shift = {shift[6:0], sda};
        bit_cnt++;
      end else if (state == mdl_tx_ack) begin
        state = mdl_idle;  // master nack ends the read
      end
    end else if (scl === 1'b0 && scl_q === 1'b1) begin
      pull_low = 1'b0;
      case (state)
        mdl_rx: begin
          if (bit_cnt == 8) begin
            take_byte();
          end
        end
        mdl_rx_ack: begin
          bit_cnt = 0;
          if (rd_mode) begin
            state        = mdl_tx;
            shift        = mem[ptr];
            last_op_read = 1'b1;
          end else begin
            state = mdl_rx;
          end
        end
        mdl_tx: begin
          if (bit_cnt == 8) begin
            state = mdl_tx_ack;
          end
        end
        default: begin
        end
      endcase
      if (state == mdl_rx_ack) begin
        pull_low <= #drive_delay 1'b1;
      end else if (state == mdl_tx && bit_cnt < 8) begin
        pull_low <= #drive_delay !shift[7];
        shift = {shift[6:0], 1'b0};
        bit_cnt++;
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

endmodule

`default_nettype wire

/* eeprom_ctrl_top.sv */
`default_nettype none

module eeprom_ctrl_top
  import eeprom_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire           wr,
  input  wire           rd,
  input  wire ee_addr_t addr,
  inout  wire byte_t    data,
  output logic          ack,
  output logic          scl,
  inout  wire           sda
);

  logic     cmd_go;
  logic     cmd_done;
  bit_cmd_t cmd;
  byte_t    tx_byte;
  byte_t    rx_byte;
  logic     sda_out;
  logic     sda_oe;

  assign sda = sda_oe ? sda_out : 1'bz;  // open bus, pulled up outside

  eeprom_wr u_eeprom_wr (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .rd       (rd),
    .addr     (addr),
    .cmd_done (cmd_done),
    .rx_byte  (rx_byte),
    .data     (data),
    .ack      (ack),
    .cmd_go   (cmd_go),
    .cmd      (cmd),
    .tx_byte  (tx_byte)
  );

  i2c_bit_engine u_bit_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_go   (cmd_go),
    .cmd      (cmd),
    .tx_byte  (tx_byte),
    .sda_in   (sda),
    .cmd_done (cmd_done),
    .rx_byte  (rx_byte),
    .scl      (scl),
    .sda_out  (sda_out),
    .sda_oe   (sda_oe)
  );

endmodule

`default_nettype wire

/* eeprom_wr.sv */
`default_nettype none

module eeprom_wr
  import eeprom_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire           wr,
  input  wire           rd,
  input  wire ee_addr_t addr,
  input  wire           cmd_done,
  input  wire byte_t    rx_byte,
  inout  wire byte_t    data,
  output logic          ack,
  output logic          cmd_go,
  output bit_cmd_t      cmd,
  output byte_t         tx_byte
);

  main_state_t main_state;
  main_state_t state_nxt;
  logic        wf;            // 1 = write cycle, 0 = read cycle
  logic        req;
  logic        issue;
  bit_cmd_t    cmd_nxt;
  byte_t       tx_nxt;
  ee_addr_t    addr_q;
  byte_t       wdata;
  byte_t       data_from_rm;  // byte read back from the device
  byte_t       ctrl_byte;

  assign req       = wr || rd;
  assign ctrl_byte = {ee_device_code, addr_q[10:8], 1'b0};

  assign ack  = (main_state == st_ackn);
  assign data = (ack && !wf) ? data_from_rm : 'z;

  // one engine command per state, next one issued on cmd_done
  always_comb begin
    state_nxt = main_state;
    issue     = 1'b0;
    cmd_nxt   = cmd_start;
    tx_nxt    = ctrl_byte;
    unique case (main_state)
      st_idle: begin
        if (req) begin
          state_nxt = st_write_start;
          issue     = 1'b1;
          cmd_nxt   = cmd_start;
        end
      end
      st_write_start: begin
        if (cmd_done) begin
          state_nxt = st_ctrl_write;
          issue     = 1'b1;
          cmd_nxt   = cmd_write;
          tx_nxt    = ctrl_byte;
        end
      end
      st_ctrl_write: begin
        if (cmd_done) begin
          state_nxt = st_addr_write;
          issue     = 1'b1;
          cmd_nxt   = cmd_write;
          tx_nxt    = addr_q[7:0];
        end
      end
      st_addr_write: begin
        if (cmd_done) begin
          issue = 1'b1;
          if (wf) begin
            state_nxt = st_data_write;
            cmd_nxt   = cmd_write;
            tx_nxt    = wdata;
          end else begin
            state_nxt = st_read_start;  // repeated start
            cmd_nxt   = cmd_start;
          end
        end
      end
      st_data_write: begin
        if (cmd_done) begin
          state_nxt = st_stop;
          issue     = 1'b1;
          cmd_nxt   = cmd_stop;
        end
      end
      st_read_start: begin
        if (cmd_done) begin
          state_nxt = st_ctrl_read;
          issue     = 1'b1;
          cmd_nxt   = cmd_write;
          tx_nxt    = ctrl_byte | 8'h01;  // r/w bit set
        end
      end
      st_ctrl_read: begin
        if (cmd_done) begin
          state_nxt = st_data_read;
          issue     = 1'b1;
          cmd_nxt   = cmd_read;
        end
      end
      st_data_read: begin
        if (cmd_done) begin
          state_nxt = st_stop;
          issue     = 1'b1;
          cmd_nxt   = cmd_stop;
        end
      end
      st_stop: begin
        if (cmd_done) begin
          state_nxt = st_ackn;
        end
      end
      st_ackn: state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_state <= st_idle;
      cmd_go     <= 1'b0;
      wf         <= 1'b0;
    end else begin
      main_state <= state_nxt;
      cmd_go     <= issue;
      if (main_state == st_idle && req) begin
        wf <= wr;  // write wins over read
      end
    end
  end

  always_ff @(posedge clk) begin
    if (main_state == st_idle && req) begin
      addr_q <= addr;
      wdata  <= data;
    end
    if (issue) begin
      cmd     <= cmd_nxt;
      tx_byte <= tx_nxt;
    end
    if (main_state == st_data_read && cmd_done) begin
      data_from_rm <= rx_byte;
    end
  end

endmodule

`default_nettype wire

/* i2c_bit_engine.sv */
`default_nettype none

module i2c_bit_engine
  import eeprom_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire           cmd_go,
  input  wire bit_cmd_t cmd,
  input  wire byte_t    tx_byte,
  input  wire           sda_in,
  output logic          cmd_done,
  output byte_t         rx_byte,
  output logic          scl,
  output logic          sda_out,
  output logic          sda_oe
);

  // one sub-machine per command, each walks its own half-period steps
  typedef enum logic [2:0] {
    mode_idle,
    mode_head,
    mode_stop,
    mode_sh8out,
    mode_sh8in
  } eng_mode_t;

  eng_mode_t mode;
  ph_cnt_t   ph_cnt;
  step_t     step;
  byte_t     sh_out;       // tx shift register
  logic      tick;         // last clk of a half-period
  logic      last_step;
  logic      data_bits;    // bits 7..0, not the ack/nack clock
  logic      sda_oe_nxt;
  logic      sda_out_nxt;

  // scl level of a given step, low first in every command
  function automatic logic scl_level(eng_mode_t m, step_t s);
    if (m == mode_head || m == mode_stop) begin
      return (s != '0);
    end
    return s[0];
  endfunction

  assign tick      = (ph_cnt == ph_cnt_t'(scl_half_cycles - 1));
  assign data_bits = (step < step_t'(byte_steps - 2));

  always_comb begin
    if (mode == mode_head || mode == mode_stop) begin
      last_step = (step == step_t'(cond_steps - 1));
    end else begin
      last_step = (step == step_t'(byte_steps - 1));
    end
  end

  // sda level wanted in the current step
  always_comb begin
    sda_oe_nxt  = sda_oe;
    sda_out_nxt = sda_out;
    unique case (mode)
      mode_head: begin
        sda_oe_nxt  = 1'b1;
        sda_out_nxt = (step != step_t'(cond_steps - 1));  // falls with scl high
      end
      mode_stop: begin
        sda_oe_nxt  = 1'b1;
        sda_out_nxt = (step == step_t'(cond_steps - 1));  // rises with scl high
      end
      mode_sh8out: begin
        if (!step[0]) begin
          sda_oe_nxt  = data_bits;  // let go for the slave ack
          sda_out_nxt = sh_out[7];
        end
      end
      mode_sh8in: begin
        if (!step[0]) begin
          sda_oe_nxt  = !data_bits;  // master nack
          sda_out_nxt = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode     <= mode_idle;
      ph_cnt   <= '0;
      step     <= '0;
      scl      <= 1'b1;
      sda_oe   <= 1'b0;
      sda_out  <= 1'b1;
      cmd_done <= 1'b0;
    end else begin
      cmd_done <= 1'b0;
      if (mode == mode_idle) begin
        if (cmd_go) begin
          unique case (cmd)
            cmd_start: mode <= mode_head;
            cmd_stop:  mode <= mode_stop;
            cmd_write: mode <= mode_sh8out;
            cmd_read:  mode <= mode_sh8in;
            default:   mode <= mode_idle;
          endcase
          step   <= '0;
          ph_cnt <= '0;
          scl    <= 1'b0;
        end
      end else begin
        // sda moves one clk into the step, away from the scl edge
        if (ph_cnt == '0) begin
          sda_oe  <= sda_oe_nxt;
          sda_out <= sda_out_nxt;
        end
        if (tick) begin
          ph_cnt <= '0;
          if (last_step) begin
            mode     <= mode_idle;
            cmd_done <= 1'b1;
            if (mode == mode_stop) begin
              sda_oe <= 1'b0;  // bus free, pull-up keeps it high
            end
          end else begin
            step <= step + step_t'(1);
            scl  <= scl_level(mode, step + step_t'(1));
          end
        end else begin
          ph_cnt <= ph_cnt + ph_cnt_t'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mode == mode_idle && cmd_go) begin
      sh_out <= tx_byte;
    end else if (mode == mode_sh8out && step[0] && tick) begin
      sh_out <= {sh_out[6:0], 1'b0};  // next bit after the high half
    end
    // sample once scl has risen
    if (mode == mode_sh8in && step[0] && data_bits && ph_cnt == '0) begin
      rx_byte <= {rx_byte[6:0], sda_in};
    end
  end

endmodule

`default_nettype wire

/* eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

  typedef logic [10:0] ee_addr_t;  // [10:8] go out in the control byte
  typedef logic [7:0]  byte_t;

  // commands understood by the bit engine
  typedef enum logic [1:0] {
    cmd_start,
    cmd_stop,
    cmd_write,
    cmd_read
  } bit_cmd_t;

  typedef enum logic [3:0] {
    st_idle,
    st_write_start,
    st_ctrl_write,
    st_addr_write,
    st_data_write,
    st_read_start,
    st_ctrl_read,
    st_data_read,
    st_stop,
    st_ackn
  } main_state_t;

  localparam logic [3:0] ee_device_code = 4'b1010;

  // clk cycles per scl half-period
  localparam int scl_half_cycles = 2;
  localparam int ph_cnt_w = (scl_half_cycles > 1) ? $clog2(scl_half_cycles) : 1;

  // half-periods per engine command
  localparam int cond_steps = 3;   // start or stop condition
  localparam int byte_steps = 18;  // 8 bits plus the ack clock

  typedef logic [ph_cnt_w-1:0]           ph_cnt_t;
  typedef logic [$clog2(byte_steps)-1:0] step_t;

endpackage

`default_nettype wire
